// ==== hdl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

  localparam int num_ways       = 4;
  localparam int tag_w          = 22;
  localparam int set_w          = 4;
  localparam int word_w         = 4;
  localparam int words_per_line = 16;

  typedef logic [31:0]       word_t;
  typedef logic [tag_w-1:0]  tag_t;
  typedef logic [set_w-1:0]  set_t;
  typedef logic [word_w-1:0] word_idx_t;
  typedef logic [1:0]        way_t;
  typedef logic [1:0]        age_t;   // 0 = most recent

  typedef word_t [words_per_line-1:0] line_t;

  typedef struct packed {
    tag_t tag;
    logic valid;
    logic dirty;
  } tag_entry_t;

  typedef struct packed {
    word_t      addr;
    word_t      wdata;
    logic       write;
    logic [3:0] byte_en;
  } cpu_req_t;

  // tag | set | word | byte from the top
  function automatic tag_t addr_tag(word_t a);
    return a[31 -: tag_w];
  endfunction

  function automatic set_t addr_set(word_t a);
    return a[2 + word_w +: set_w];
  endfunction

  function automatic word_idx_t addr_word(word_t a);
    return a[2 +: word_w];
  endfunction

endpackage

`default_nettype wire

// ==== hdl/line_ram.sv ====
`default_nettype none

module line_ram #(
  parameter type entry_t = logic
) (
  input  wire                    clk,
  input  wire                    rst,
  input  wire dcache_pkg::set_t  rd_set,
  output entry_t                 rd_entry,
  input  wire                    wr_en,
  input  wire dcache_pkg::set_t  wr_set,
  input  wire entry_t            wr_entry
);

  localparam int depth = 2 ** dcache_pkg::set_w;

  entry_t mem [depth];

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < depth; i++)
        mem[i] <= '0;   // invalid, clean
    end
    else if (wr_en)
    begin
      mem[wr_set] <= wr_entry;
    end
  end

  assign rd_entry = mem[rd_set];   // async read

endmodule

`default_nettype wire

// ==== hdl/way_lookup.sv ====
`default_nettype none

module way_lookup (
  input  wire                                                  clk,
  input  wire                                                  rst,
  input  wire dcache_pkg::set_t                                set,
  input  wire dcache_pkg::tag_t                                tag,
  input  wire dcache_pkg::tag_entry_t [dcache_pkg::num_ways-1:0] tags,
  input  wire                                                  touch,
  input  wire dcache_pkg::way_t                                touch_way,
  output logic                                                 hit,
  output dcache_pkg::way_t                                     hit_way,
  output dcache_pkg::way_t                                     victim_way
);

  localparam int ways = dcache_pkg::num_ways;
  localparam int sets = 2 ** dcache_pkg::set_w;

  dcache_pkg::age_t ages [sets][ways];
  logic [ways-1:0]  hit_vec;

  always_comb
  begin
    hit_way = '0;
    for (int w = 0; w < ways; w++)
      hit_vec[w] = tags[w].valid && (tags[w].tag == tag);
    for (int w = ways - 1; w >= 0; w--)
      if (hit_vec[w]) hit_way = dcache_pkg::way_t'(w);
  end

  assign hit = |hit_vec;

  // lowest invalid way wins over the oldest one
  always_comb
  begin
    victim_way = '0;
    for (int w = 1; w < ways; w++)
      if (ages[set][w] > ages[set][victim_way]) victim_way = dcache_pkg::way_t'(w);
    for (int w = ways - 1; w >= 0; w--)
      if (!tags[w].valid) victim_way = dcache_pkg::way_t'(w);
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < sets; s++)
        for (int w = 0; w < ways; w++)
          ages[s][w] <= dcache_pkg::age_t'(w);
    end
    else if (touch)
    begin
      for (int w = 0; w < ways; w++)
        if (dcache_pkg::way_t'(w) == touch_way)
          ages[set][w] <= '0;
        else if (ages[set][w] < ages[set][touch_way])
          ages[set][w] <= ages[set][w] + 1'b1;   // younger ones age by one
    end
  end

endmodule

`default_nettype wire

// ==== hdl/line_fill.sv ====
`default_nettype none

module line_fill (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     start,
  input  wire dcache_pkg::word_t  addr,
  output logic                    sen,
  output dcache_pkg::word_t       raddr,
  input  wire                     rdata_ok,
  input  wire dcache_pkg::word_t  sdata,
  output dcache_pkg::line_t       line,
  output logic                    done
);

  logic                  active;
  dcache_pkg::word_idx_t cnt;
  dcache_pkg::word_idx_t slot;
  dcache_pkg::word_t     addr_q;

  // burst wraps from the requested word
  assign slot  = dcache_pkg::addr_word(addr_q) + cnt;
  assign sen   = active;
  assign raddr = addr_q;
  assign done  = active && rdata_ok && (cnt == dcache_pkg::word_idx_t'(15));

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      active <= 1'b0;
      cnt    <= '0;
    end
    else if (start)
    begin
      active <= 1'b1;
      cnt    <= '0;
    end
    else if (active && rdata_ok)
    begin
      cnt <= cnt + 1'b1;
      if (done) active <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (start) addr_q <= addr;
    if (active && rdata_ok) line[slot] <= sdata;
  end

endmodule

`default_nettype wire

// ==== hdl/line_evict.sv ====
`default_nettype none

module line_evict (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     start,
  input  wire dcache_pkg::word_t  base,
  input  wire dcache_pkg::line_t  line,
  output logic                    wen,
  output dcache_pkg::word_t       waddr,
  output dcache_pkg::word_t       wdata,
  input  wire                     wdata_ok,
  output logic                    done
);

  logic                  active;
  dcache_pkg::word_idx_t cnt;
  dcache_pkg::word_t     base_q;
  dcache_pkg::line_t     line_q;

  assign wen   = active;
  assign waddr = base_q;
  assign wdata = line_q[cnt];   // word k of the victim
  assign done  = active && wdata_ok && (cnt == dcache_pkg::word_idx_t'(15));

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      active <= 1'b0;
      cnt    <= '0;
    end
    else if (start)
    begin
      active <= 1'b1;
      cnt    <= '0;
    end
    else if (active && wdata_ok)
    begin
      cnt <= cnt + 1'b1;
      if (done) active <= 1'b0;
    end
  end

  // victim line held for the whole burst
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      base_q <= base;
      line_q <= line;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/dcache_ctrl.sv ====
`default_nettype none

module dcache_ctrl (
  input  wire                                                    clk,
  input  wire                                                    rst,
  input  wire                                                    req,
  input  wire dcache_pkg::cpu_req_t                              cpu,
  output dcache_pkg::word_t                                      rdata,
  output logic                                                   ok,
  output logic                                                   miss,
  input  wire dcache_pkg::tag_entry_t [dcache_pkg::num_ways-1:0] tags,
  input  wire dcache_pkg::line_t [dcache_pkg::num_ways-1:0]      lines,
  input  wire                                                    hit,
  input  wire dcache_pkg::way_t                                  hit_way,
  input  wire dcache_pkg::way_t                                  victim_way,
  output logic                                                   touch,
  output dcache_pkg::way_t                                       touch_way,
  output logic [dcache_pkg::num_ways-1:0]                        tag_we,
  output logic [dcache_pkg::num_ways-1:0]                        data_we,
  output dcache_pkg::set_t                                       wr_set,
  output dcache_pkg::tag_entry_t                                 wr_tag,
  output dcache_pkg::line_t                                      wr_line,
  output logic                                                   fill_start,
  output dcache_pkg::word_t                                      fill_addr,
  input  wire                                                    fill_done,
  input  wire dcache_pkg::line_t                                 fill_line,
  output logic                                                   evict_start,
  input  wire                                                    evict_done,
  output dcache_pkg::word_t                                      evict_base,
  output dcache_pkg::line_t                                      evict_line
);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_evict,
    st_fill,
    st_install
  } state_t;

  state_t                state, next;
  dcache_pkg::cpu_req_t req_q;
  dcache_pkg::way_t     vway;
  dcache_pkg::word_idx_t idx;
  dcache_pkg::line_t    base_line;

  function automatic dcache_pkg::line_t merge(dcache_pkg::line_t l, dcache_pkg::word_idx_t i,
                                              dcache_pkg::word_t d, logic [3:0] be);
    dcache_pkg::line_t r;
    r = l;
    for (int b = 0; b < 4; b++)
      if (be[b]) r[i][8*b +: 8] = d[8*b +: 8];
    return r;
  endfunction

  assign idx        = dcache_pkg::addr_word(req_q.addr);
  assign wr_set     = dcache_pkg::addr_set(req_q.addr);
  assign fill_addr  = req_q.addr;
  assign evict_line = lines[victim_way];
  assign evict_base = {tags[victim_way].tag, wr_set, {(dcache_pkg::word_w + 2){1'b0}}};

  // hit line in lookup and refilled line on install
  assign base_line = (state == st_install) ? fill_line : lines[hit_way];
  assign wr_line   = req_q.write ? merge(base_line, idx, req_q.wdata, req_q.byte_en) : base_line;
  assign rdata     = req_q.write ? req_q.wdata : base_line[idx];

  ////////////////////////////////////////////////////////////////////////////
  // main FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    next        = state;
    ok          = 1'b0;
    miss        = 1'b0;
    touch       = 1'b0;
    touch_way   = hit_way;
    tag_we      = '0;
    data_we     = '0;
    fill_start  = 1'b0;
    evict_start = 1'b0;
    wr_tag.tag   = dcache_pkg::addr_tag(req_q.addr);
    wr_tag.valid = 1'b1;
    wr_tag.dirty = 1'b1;
    case (state)
      st_idle:
        if (req) next = st_lookup;
      st_lookup:
        if (hit)
        begin
          ok    = 1'b1;
          touch = 1'b1;
          tag_we[hit_way]  = req_q.write;   // mark dirty
          data_we[hit_way] = req_q.write;
          next  = st_idle;
        end
        else
        begin
          miss = 1'b1;
          if (tags[victim_way].valid && tags[victim_way].dirty)
          begin
            evict_start = 1'b1;
            next        = st_evict;
          end
          else
          begin
            fill_start = 1'b1;
            next       = st_fill;
          end
        end
      st_evict:
      begin
        miss = 1'b1;
        if (evict_done)
        begin
          fill_start = 1'b1;   // refill starts after the write-back
          next       = st_fill;
        end
      end
      st_fill:
      begin
        miss = 1'b1;
        if (fill_done) next = st_install;
      end
      st_install:
      begin
        miss          = 1'b1;
        ok            = 1'b1;
        touch         = 1'b1;
        touch_way     = vway;
        tag_we[vway]  = 1'b1;
        data_we[vway] = 1'b1;
        wr_tag.dirty  = req_q.write;
        next          = st_idle;
      end
      default:
        next = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst) state <= st_idle;
    else     state <= next;
  end

  always_ff @(posedge clk)
  begin
    if (state == st_idle && req) req_q <= cpu;
    if (state == st_lookup) vway <= victim_way;
  end

endmodule

`default_nettype wire

// ==== hdl/dcache_top.sv ====
`default_nettype none

module dcache_top (
  input  wire                        clk,
  input  wire                        rst,
  // CPU side
  input  wire                        req,
  input  wire dcache_pkg::cpu_req_t  cpu,
  output dcache_pkg::word_t          rdata,
  output logic                       ok,
  output logic                       miss,
  // memory read
  output logic                       sen,
  output dcache_pkg::word_t          raddr,
  input  wire                        rdata_ok,
  input  wire dcache_pkg::word_t     sdata,
  // memory write
  output logic                       wen,
  output dcache_pkg::word_t          waddr,
  output dcache_pkg::word_t          wdata,
  input  wire                        wdata_ok
);

  localparam int ways = dcache_pkg::num_ways;

  dcache_pkg::tag_entry_t [ways-1:0] tags;
  dcache_pkg::line_t [ways-1:0]      lines;
  logic [ways-1:0]                   tag_we, data_we;
  dcache_pkg::set_t                  wr_set;
  dcache_pkg::tag_entry_t            wr_tag;
  dcache_pkg::line_t                 wr_line;
  logic                              hit, touch;
  dcache_pkg::way_t                  hit_way, victim_way, touch_way;
  logic                              fill_start, fill_done, evict_start, evict_done;
  dcache_pkg::word_t                 fill_addr, evict_base;
  dcache_pkg::line_t                 fill_line, evict_line;

  ////////////////////////////////////////////////////////////////////////////
  // tag and data storage, one pair per way
  ////////////////////////////////////////////////////////////////////////////

  for (genvar w = 0; w < ways; w++)
  begin : g_way
    line_ram #(.entry_t(dcache_pkg::tag_entry_t)) i_tag_ram (
      .clk(clk), .rst(rst),
      .rd_set(wr_set), .rd_entry(tags[w]),
      .wr_en(tag_we[w]), .wr_set(wr_set), .wr_entry(wr_tag)
    );
    line_ram #(.entry_t(dcache_pkg::line_t)) i_data_ram (
      .clk(clk), .rst(rst),
      .rd_set(wr_set), .rd_entry(lines[w]),
      .wr_en(data_we[w]), .wr_set(wr_set), .wr_entry(wr_line)
    );
  end

  way_lookup i_way_lookup (
    .clk(clk), .rst(rst),
    .set(wr_set), .tag(dcache_pkg::addr_tag(fill_addr)), .tags(tags),
    .touch(touch), .touch_way(touch_way),
    .hit(hit), .hit_way(hit_way), .victim_way(victim_way)
  );

  dcache_ctrl i_dcache_ctrl (
    .clk(clk), .rst(rst),
    .req(req), .cpu(cpu), .rdata(rdata), .ok(ok), .miss(miss),
    .tags(tags), .lines(lines),
    .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
    .touch(touch), .touch_way(touch_way),
    .tag_we(tag_we), .data_we(data_we),
    .wr_set(wr_set), .wr_tag(wr_tag), .wr_line(wr_line),
    .fill_start(fill_start), .fill_addr(fill_addr),
    .fill_done(fill_done), .fill_line(fill_line),
    .evict_start(evict_start), .evict_done(evict_done),
    .evict_base(evict_base), .evict_line(evict_line)
  );

  line_fill i_line_fill (
    .clk(clk), .rst(rst),
    .start(fill_start), .addr(fill_addr),
    .sen(sen), .raddr(raddr), .rdata_ok(rdata_ok), .sdata(sdata),
    .line(fill_line), .done(fill_done)
  );

  line_evict i_line_evict (
    .clk(clk), .rst(rst),
    .start(evict_start), .base(evict_base), .line(evict_line),
    .wen(wen), .waddr(waddr), .wdata(wdata), .wdata_ok(wdata_ok),
    .done(evict_done)
  );

endmodule

`default_nettype wire

// ==== tests/dcache_props.sv ====
`default_nettype none

module dcache_props (
  input wire clk,
  input wire rst,
  input wire ok,
  input wire miss,
  input wire sen,
  input wire wen
);

  // read and write bursts never overlap
  a_bus_excl: assert property (@(posedge clk) disable iff (rst) !(sen && wen))
    else $error("sen and wen high in the same cycle");

  a_ok_pulse: assert property (@(posedge clk) disable iff (rst) ok |=> !ok)
    else $error("ok held for two cycles");

  a_miss_after_ok: assert property (@(posedge clk) disable iff (rst) ok |=> !miss)
    else $error("miss high in the cycle after ok");

  a_wen_rise: assert property (@(posedge clk) disable iff (rst) $rose(wen) |-> !sen && !$past(sen))
    else $error("write-back started while a refill was running");

endmodule

bind dcache_top dcache_props i_dcache_props (
  .clk(clk), .rst(rst), .ok(ok), .miss(miss), .sen(sen), .wen(wen)
);

`default_nettype wire

// ==== tests/dcache_tb.sv ====
`default_nettype none

module dcache_tb;

  localparam int ok_limit = 150;   // cycles one request may take

  typedef struct packed {
    logic [8*12-1:0]   name;
    logic              write;
    dcache_pkg::word_t addr;
    logic [3:0]        byte_en;
    dcache_pkg::word_t wdata;
    dcache_pkg::word_t exp_data;
    logic              exp_hit;
  } vector_t;

  logic                 clk, rst, req, ok, miss;
  logic                 sen, wen, rdata_ok, wdata_ok;
  dcache_pkg::cpu_req_t cpu;
  dcache_pkg::word_t    rdata, raddr, sdata, waddr, wdata;

  dcache_pkg::word_t mem [dcache_pkg::word_t];   // sparse backing memory
  vector_t           vecs [$];
  logic [8*12-1:0]   cur_name;
  int                seed;
  int                errors;
  int                passed;
  int                limit_cycles = 0;

  dcache_top i_dcache_top (
    .clk(clk), .rst(rst),
    .req(req), .cpu(cpu), .rdata(rdata), .ok(ok), .miss(miss),
    .sen(sen), .raddr(raddr), .rdata_ok(rdata_ok), .sdata(sdata),
    .wen(wen), .waddr(waddr), .wdata(wdata), .wdata_ok(wdata_ok)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic dcache_pkg::word_t read_word(dcache_pkg::word_t a);
    if (mem.exists(a))
      return mem[a];
    return a ^ 32'hA5A5_0000;   // unwritten pattern
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // memory model with gapped strobes
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin : mem_model
    logic [4:0] rk;
    logic [4:0] wk;
    logic [3:0] idx;
    seed     = 32'h9838_1b67;
    rdata_ok = 1'b0;
    wdata_ok = 1'b0;
    sdata    = '0;
    rk       = '0;
    wk       = '0;
    forever
    begin
      @(posedge clk);
      #1;
      rdata_ok = 1'b0;
      if (!sen)
        rk = '0;
      else if (rk < 5'd16 && ($random(seed) & 3) != 0)
      begin
        if (rk == 5'd0)
        begin
          assert (raddr == cpu.addr)
          else
          begin
            $display("FAIL %0s raddr expected %08h actual %08h", cur_name, cpu.addr, raddr);
            errors++;
          end
        end
        idx      = raddr[5:2] + rk[3:0];   // wraps inside the line
        sdata    = read_word({raddr[31:6], idx, 2'b00});
        rdata_ok = 1'b1;
        rk       = rk + 5'd1;
      end
      wdata_ok = 1'b0;
      if (!wen)
        wk = '0;
      else if (wk < 5'd16 && ($random(seed) & 3) != 0)
      begin
        if (wk == 5'd0)
        begin
          assert (waddr[5:0] == 6'd0)
          else
          begin
            $display("test %0s: write-back address %08h is not a line base", cur_name, waddr);
            errors++;
          end
        end
        mem[{waddr[31:6], wk[3:0], 2'b00}] = wdata;
        wdata_ok = 1'b1;
        wk       = wk + 5'd1;
      end
    end
  end

  task automatic run_vector(input vector_t v);
    int                cycles;
    int                errors_before;
    logic              got_ok;
    logic              saw_miss;
    logic              was_hit;
    dcache_pkg::word_t got_data;
    errors_before = errors;
    cycles        = 0;
    got_ok        = 1'b0;
    saw_miss      = 1'b0;
    got_data      = '0;
    cur_name      = v.name;
    @(posedge clk);
    #1;
    req         = 1'b1;
    cpu.addr    = v.addr;
    cpu.wdata   = v.wdata;
    cpu.write   = v.write;
    cpu.byte_en = v.byte_en;
    @(posedge clk);
    #1;
    req = 1'b0;
    while (!got_ok && cycles < ok_limit)
    begin
      @(negedge clk);
      cycles++;
      if (miss) saw_miss = 1'b1;
      if (ok)
      begin
        got_ok   = 1'b1;
        got_data = rdata;
      end
    end
    assert (got_ok)
    else
    begin
      $display("test %0s: no ok from the cache within %0d cycles", v.name, ok_limit);
      errors++;
    end
    if (got_ok)
    begin
      was_hit = (cycles == 1) && !saw_miss;
      assert (got_data == v.exp_data)
      else
      begin
        $display("FAIL %0s rdata expected %08h actual %08h", v.name, v.exp_data, got_data);
        errors++;
      end
      assert (was_hit == v.exp_hit)
      else
      begin
        $display("FAIL %0s hit expected %0d actual %0d", v.name, v.exp_hit, was_hit);
        errors++;
      end
    end
    if (errors == errors_before) passed++;
    $display("test %0s: %s after %0d cycles", v.name,
             (errors == errors_before) ? "pass" : "fail", cycles);
  endtask

  initial
  begin : main
    int                fd;
    int                fields;
    int                t_hit;
    string             text;
    logic [8*12-1:0]   t_name;
    logic [15:0]       t_op;
    logic [3:0]        t_be;
    dcache_pkg::word_t t_addr, t_data, t_exp;
    vector_t           v;
    errors   = 0;
    passed   = 0;
    cur_name = '0;
    rst      = 1'b1;
    req      = 1'b0;
    cpu      = '0;
    fd = $fopen("tests/dcache_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("cannot open the vector file tests/dcache_vectors.txt");
      errors++;
    end
    else
    begin
      while ($fgets(text, fd) != 0)
      begin
        if (text.len() < 2 || text.getc(0) == "#")
          continue;
        fields = $sscanf(text, "%s %s %h %h %h %h %d",
                         t_name, t_op, t_addr, t_be, t_data, t_exp, t_hit);
        if (fields != 7)
        begin
          $display("malformed vector line: %s", text);
          errors++;
        end
        else
        begin
          v.name     = t_name;
          v.write    = (t_op == "wr");
          v.addr     = t_addr;
          v.byte_en  = t_be;
          v.wdata    = t_data;
          v.exp_data = t_exp;
          v.exp_hit  = (t_hit != 0);
          vecs.push_back(v);
        end
      end
      $fclose(fd);
    end
    if (vecs.size() == 0)
    begin
      $display("no vectors were loaded");
      errors++;
    end
    limit_cycles = vecs.size() * 200;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    foreach (vecs[i])
      run_vector(vecs[i]);
    $display("tests %0d, passed %0d, failed %0d, check errors %0d",
             vecs.size(), passed, vecs.size() - passed, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  initial
  begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
hdl/dcache_pkg.sv
hdl/line_ram.sv
hdl/way_lookup.sv
hdl/line_fill.sv
hdl/line_evict.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
tests/dcache_props.sv
tests/dcache_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Verilator build and run of the dcache testbench

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -sv --top-module dcache_tb -f compile.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/Vdcache_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" "$log"; then
  echo "simulation reported failures, see $log"
  exit 1
fi
if ! grep -q "All checks passed" "$log"; then
  echo "no result line found in $log"
  exit 1
fi
echo "simulation passed"

// ==== tests/dcache_vectors.txt ====
# name op addr byte_en wdata exp_rdata exp_hit  (hex fields, op is rd or wr)
# exp_hit 1 means ok one cycle after req with miss low, 0 means a miss
cold_rd  rd 000010a4 f 00000000 a5a510a4 0
hit_rd   rd 00001088 f 00000000 a5a51088 1
wr_hit   wr 00001090 5 11223344 11223344 1
rd_merge rd 00001090 f 00000000 a5221044 1
fill_b   rd 00001480 f 00000000 a5a51480 0
fill_c   rd 000018a0 f 00000000 a5a518a0 0
fill_d   rd 00001cb8 f 00000000 a5a51cb8 0
evict_a  rd 000020bc f 00000000 a5a520bc 0
b_kept   rd 000014b4 f 00000000 a5a514b4 1
a_back   rd 00001090 f 00000000 a5221044 0
a_other  rd 00001094 f 00000000 a5a51094 1
d_kept   rd 00001c80 f 00000000 a5a51c80 1
c_gone   rd 000018a0 f 00000000 a5a518a0 0
wr_miss  wr 00003148 c deadbeef deadbeef 0
rd_wmiss rd 00003148 f 00000000 dead3148 1
rd_wnext rd 00003144 f 00000000 a5a53144 1
